// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_gmii_udp_rx
FILELIST = gmii_udp_rx.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: gmii_udp_rx.f
rtl/udp_rx_pkg.sv
rtl/rx_byte_counter.sv
rtl/rx_udp_fsm.sv
rtl/header_capture.sv
rtl/payload_gate.sv
rtl/gmii_udp_rx.sv
testbench/gmii_udp_rx_properties.sv
testbench/tb_gmii_udp_rx.sv

// File: rtl/gmii_udp_rx.sv
// Receive-only GMII to UDP payload extractor on a single clock
// No back-pressure: the payload stream must be consumed as it arrives
// Latency from gmii_rxd to payload_data is two clock cycles
`timescale 1ns/1ps
`default_nettype none

module gmii_udp_rx (
    input  wire        logic_clk,
    input  wire        rst,
    input  wire [7:0]  gmii_rxd,
    input  wire        gmii_rx_dv,
    input  wire        gmii_rx_er,
    output logic [7:0] payload_data,
    output logic       payload_valid,
    output logic       payload_last,
    output logic       payload_user,
    output logic       payload_abort
);

    import udp_rx_pkg::*;

    logic [7:0]  rxd_q;
    logic        rx_dv_q;
    logic        rx_er_q;
    logic        count_clear;
    logic        count_enable;
    offset_t     offset;
    logic        capture_enable;
    logic        header_match;
    logic [15:0] payload_len;
    logic        frame_start;
    logic        pass;
    logic        pass_last;
    logic        abort;

    // GMII input register
    always_ff @(posedge logic_clk) begin
        if (rst) begin
            rx_dv_q <= 1'b0;
            rx_er_q <= 1'b0;
        end else begin
            rx_dv_q <= gmii_rx_dv;
            rx_er_q <= gmii_rx_er;
        end
    end

    always_ff @(posedge logic_clk) begin
        rxd_q <= gmii_rxd;
    end

    rx_udp_fsm u_fsm (
        .logic_clk      (logic_clk),
        .rst            (rst),
        .rx_dv          (rx_dv_q),
        .rx_data        (rxd_q),
        .offset         (offset),
        .header_match   (header_match),
        .payload_len    (payload_len),
        .count_clear    (count_clear),
        .count_enable   (count_enable),
        .capture_enable (capture_enable),
        .frame_start    (frame_start),
        .pass           (pass),
        .pass_last      (pass_last),
        .abort          (abort)
    );

    rx_byte_counter u_counter (
        .logic_clk    (logic_clk),
        .rst          (rst),
        .count_clear  (count_clear),
        .count_enable (count_enable),
        .offset       (offset)
    );

    header_capture u_capture (
        .logic_clk      (logic_clk),
        .rst            (rst),
        .capture_enable (capture_enable),
        .offset         (offset),
        .rx_data        (rxd_q),
        .header_match   (header_match),
        .payload_len    (payload_len)
    );

    payload_gate u_gate (
        .logic_clk     (logic_clk),
        .rst           (rst),
        .rx_data       (rxd_q),
        .rx_er         (rx_er_q),
        .frame_start   (frame_start),
        .pass          (pass),
        .pass_last     (pass_last),
        .abort         (abort),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .payload_last  (payload_last),
        .payload_user  (payload_user),
        .payload_abort (payload_abort)
    );

endmodule

`default_nettype wire

// File: rtl/header_capture.sv
// Captures Ethernet, IPv4 and UDP header fields by byte offset
// Match flags settle one cycle after the last byte of their field
// Checksums, source fields and IP total length are not examined
`timescale 1ns/1ps
`default_nettype none

module header_capture (
    input  wire                  logic_clk,
    input  wire                  rst,
    input  wire                  capture_enable,
    input  wire udp_rx_pkg::offset_t offset,
    input  wire [7:0]            rx_data,
    output logic                 header_match,
    output logic [15:0]          payload_len
);

    import udp_rx_pkg::*;

    logic [47:0] dest_mac;
    logic [15:0] eth_type;
    logic [31:0] dest_ip;
    logic [15:0] dest_port;
    logic [15:0] udp_len;
    logic        mac_ok;
    logic        type_ok;
    logic        ver_ok;
    logic        proto_ok;
    logic        ip_ok;
    logic        port_ok;

    // True while pos lies inside a field of len bytes starting at first
    function automatic logic in_field(offset_t pos, offset_t first, int unsigned len);
        offset_t rel;
        rel = pos - first;
        return rel < len;
    endfunction

    // Field shift registers
    always_ff @(posedge logic_clk) begin
        if (capture_enable) begin
            if (in_field(offset, off_dest_mac, 6)) dest_mac <= {dest_mac[39:0], rx_data};
            if (in_field(offset, off_eth_type, 2)) eth_type <= {eth_type[7:0], rx_data};
            if (in_field(offset, off_dest_ip, 4)) dest_ip <= {dest_ip[23:0], rx_data};
            if (in_field(offset, off_dest_port, 2)) dest_port <= {dest_port[7:0], rx_data};
            if (in_field(offset, off_udp_len, 2)) udp_len <= {udp_len[7:0], rx_data};
        end
    end

    // Flags judged on the closing byte of each field
    always_ff @(posedge logic_clk) begin
        if (rst) begin
            mac_ok   <= 1'b0;
            type_ok  <= 1'b0;
            ver_ok   <= 1'b0;
            proto_ok <= 1'b0;
            ip_ok    <= 1'b0;
            port_ok  <= 1'b0;
        end else if (capture_enable) begin
            if (offset == off_dest_mac) begin
                type_ok  <= 1'b0;
                ver_ok   <= 1'b0;
                proto_ok <= 1'b0;
                ip_ok    <= 1'b0;
                port_ok  <= 1'b0;
            end
            if (offset == off_dest_mac + 11'd5) begin
                mac_ok <= ({dest_mac[39:0], rx_data} == local_mac)
                       || ({dest_mac[39:0], rx_data} == broadcast_mac);
            end
            if (offset == off_eth_type + 11'd1) type_ok <= {eth_type[7:0], rx_data} == eth_type_ipv4;
            if (offset == off_ver_ihl) ver_ok <= rx_data == ip_ver_ihl;
            if (offset == off_proto) proto_ok <= rx_data == ip_proto_udp;
            if (offset == off_dest_ip + 11'd3) ip_ok <= {dest_ip[23:0], rx_data} == local_ip;
            if (offset == off_dest_port + 11'd1) begin
                port_ok <= {dest_port[7:0], rx_data} == udp_listen_port;
            end
        end
    end

    assign header_match = mac_ok && type_ok && ver_ok && proto_ok && ip_ok && port_ok;
    assign payload_len  = udp_len - udp_hdr_len;

endmodule

`default_nettype wire

// File: rtl/payload_gate.sv
// Output register stage for accepted payload bytes
// payload_user carries the frame error seen so far, sticky until the next frame
`timescale 1ns/1ps
`default_nettype none

module payload_gate (
    input  wire        logic_clk,
    input  wire        rst,
    input  wire [7:0]  rx_data,
    input  wire        rx_er,
    input  wire        frame_start,
    input  wire        pass,
    input  wire        pass_last,
    input  wire        abort,
    output logic [7:0] payload_data,
    output logic       payload_valid,
    output logic       payload_last,
    output logic       payload_user,
    output logic       payload_abort
);

    logic err_flag;

    always_ff @(posedge logic_clk) begin
        if (rst) begin
            err_flag      <= 1'b0;
            payload_valid <= 1'b0;
            payload_last  <= 1'b0;
            payload_user  <= 1'b0;
            payload_abort <= 1'b0;
        end else begin
            // First preamble byte starts a clean frame
            err_flag      <= frame_start ? rx_er : (err_flag | rx_er);
            payload_valid <= pass;
            payload_last  <= pass_last;
            payload_user  <= pass && (err_flag || rx_er);
            payload_abort <= abort;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (pass) begin
            payload_data <= rx_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rx_byte_counter.sv
// Byte counter for the receive path
// Saturates at its maximum, so frames longer than 2047 bytes after
// the SFD stop counting rather than wrap
`timescale 1ns/1ps
`default_nettype none

module rx_byte_counter (
    input  wire                  logic_clk,
    input  wire                  rst,
    input  wire                  count_clear,
    input  wire                  count_enable,
    output udp_rx_pkg::offset_t  offset
);

    import udp_rx_pkg::*;

    localparam offset_t offset_max = {offset_w{1'b1}};

    always_ff @(posedge logic_clk) begin
        if (rst) begin
            offset <= '0;
        end else if (count_clear) begin
            offset <= '0;
        end else if (count_enable && offset != offset_max) begin
            offset <= offset + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rx_udp_fsm.sv
// Frame tracking FSM for the GMII UDP receiver
// Inputs are the registered GMII signals; all outputs are combinational
// Payloads that run past the counter limit end with an abort
`timescale 1ns/1ps
`default_nettype none

module rx_udp_fsm (
    input  wire                  logic_clk,
    input  wire                  rst,
    input  wire                  rx_dv,
    input  wire [7:0]            rx_data,
    input  wire udp_rx_pkg::offset_t offset,
    input  wire                  header_match,
    input  wire [15:0]           payload_len,
    output logic                 count_clear,
    output logic                 count_enable,
    output logic                 capture_enable,
    output logic                 frame_start,
    output logic                 pass,
    output logic                 pass_last,
    output logic                 abort
);

    import udp_rx_pkg::*;

    rx_state_t   state;
    rx_state_t   state_next;
    logic [16:0] end_off;
    logic        at_last;
    logic        accept;

    // Offset of the final payload byte
    assign end_off = 17'(hdr_len) + 17'(payload_len) - 17'd1;
    assign at_last = 17'(offset) == end_off;
    // Empty payloads carry nothing to deliver
    assign accept  = header_match && (payload_len != 16'd0);

    always_ff @(posedge logic_clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next     = state;
        count_clear    = 1'b0;
        count_enable   = 1'b0;
        capture_enable = 1'b0;
        frame_start    = 1'b0;
        pass           = 1'b0;
        pass_last      = 1'b0;
        abort          = 1'b0;
        case (state)
            s_idle: begin
                if (rx_dv) begin
                    if (rx_data == gmii_preamble) begin
                        frame_start = 1'b1;
                        state_next  = s_preamble;
                    end else begin
                        state_next = s_drop;
                    end
                end
            end
            s_preamble: begin
                if (!rx_dv) begin
                    state_next = s_idle;
                end else if (rx_data == gmii_sfd) begin
                    count_clear = 1'b1;
                    state_next  = s_header;
                end else if (rx_data != gmii_preamble) begin
                    state_next = s_drop;
                end
            end
            s_header: begin
                if (!rx_dv) begin
                    state_next = s_idle;
                end else if (offset == hdr_len) begin
                    // Header complete, first payload byte is on rx_data
                    if (accept) begin
                        pass         = 1'b1;
                        pass_last    = at_last;
                        count_enable = 1'b1;
                        state_next   = at_last ? s_wait_end : s_payload;
                    end else begin
                        state_next = s_drop;
                    end
                end else begin
                    capture_enable = 1'b1;
                    count_enable   = 1'b1;
                end
            end
            s_payload: begin
                if (!rx_dv) begin
                    abort      = 1'b1;
                    state_next = s_idle;
                end else begin
                    pass         = 1'b1;
                    pass_last    = at_last;
                    count_enable = 1'b1;
                    if (at_last) begin
                        state_next = s_wait_end;
                    end
                end
            end
            s_drop, s_wait_end: begin
                if (!rx_dv) begin
                    state_next = s_idle;
                end
            end
            default: state_next = s_idle;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/udp_rx_pkg.sv
// Shared constants and types for the GMII UDP receiver
// Only fixed 20-byte IPv4 headers (no options) are recognized
// Local addresses are fixed at elaboration, not run-time registers
`default_nettype none

package udp_rx_pkg;

    // GMII framing
    localparam logic [7:0] gmii_preamble = 8'h55;
    localparam logic [7:0] gmii_sfd      = 8'hD5;

    // Protocol values
    localparam logic [15:0] eth_type_ipv4 = 16'h0800;
    localparam logic [7:0]  ip_ver_ihl    = 8'h45;
    localparam logic [7:0]  ip_proto_udp  = 8'd17;

    // Local configuration
    localparam logic [47:0] local_mac       = 48'h02_CA_FE_12_34_56;
    localparam logic [47:0] broadcast_mac   = 48'hFF_FF_FF_FF_FF_FF;
    localparam logic [31:0] local_ip        = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [15:0] udp_listen_port = 16'd1234;
    localparam logic [15:0] udp_hdr_len     = 16'd8;

    localparam int offset_w = 11;
    typedef logic [offset_w-1:0] offset_t;

    // Ethernet + IPv4 + UDP header bytes
    localparam offset_t hdr_len = 11'd42;

    // Field positions counted from the first byte after the SFD
    localparam offset_t off_dest_mac  = 11'd0;
    localparam offset_t off_eth_type  = 11'd12;
    localparam offset_t off_ver_ihl   = 11'd14;
    localparam offset_t off_proto     = 11'd23;
    localparam offset_t off_dest_ip   = 11'd30;
    localparam offset_t off_dest_port = 11'd36;
    localparam offset_t off_udp_len   = 11'd38;

    typedef enum logic [2:0] {
        s_idle,
        s_preamble,
        s_header,
        s_payload,
        s_drop,
        s_wait_end
    } rx_state_t;

endpackage

`default_nettype wire

// File: testbench/gmii_udp_rx_properties.sv
// Output strobe rules of the GMII UDP receiver, bound into the top level
// Checks start once reset has been sampled
`timescale 1ns/1ps
`default_nettype none

module gmii_udp_rx_properties (
    input wire logic_clk,
    input wire rst,
    input wire payload_valid,
    input wire payload_last,
    input wire payload_abort
);

    // Last marks a delivered byte
    last_with_valid: assert property (@(posedge logic_clk) disable iff (rst)
        payload_last |-> payload_valid)
        else $error("payload_last high without payload_valid");

    // Abort only follows a delivered byte
    abort_after_valid: assert property (@(posedge logic_clk) disable iff (rst)
        payload_abort |-> $past(payload_valid))
        else $error("payload_abort without a preceding payload byte");

    abort_not_last: assert property (@(posedge logic_clk) disable iff (rst)
        !(payload_abort && payload_last))
        else $error("payload_abort and payload_last in the same cycle");

    quiet_in_reset: assert property (@(posedge logic_clk)
        $past(rst) |-> !payload_valid)
        else $error("payload_valid high during reset");

endmodule

bind gmii_udp_rx gmii_udp_rx_properties u_props (
    .logic_clk     (logic_clk),
    .rst           (rst),
    .payload_valid (payload_valid),
    .payload_last  (payload_last),
    .payload_abort (payload_abort)
);

`default_nettype wire

// File: testbench/tb_gmii_udp_rx.sv
// Testbench for the GMII UDP receiver, run from the project root
// Frames are described in testbench/udp_rx_stim.txt, one per line
// Results are checked after each inter-frame gap, which covers the DUT latency
`timescale 1ns/1ps
`default_nettype none

module tb_gmii_udp_rx;

    import udp_rx_pkg::*;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 10;
    localparam int max_tests    = 64;
    localparam int gap_cycles   = 12;
    localparam int preamble_len = 7;
    localparam int fcs_len      = 4;
    localparam int hdr_bytes    = 42;

    localparam logic [15:0] no_index      = 16'hFFFF;
    localparam logic [15:0] tb_ipv4_type  = 16'h0800;
    localparam logic [7:0]  tb_udp_proto  = 8'd17;
    localparam logic [7:0]  tb_ver_ihl    = 8'h45;
    localparam logic [47:0] tb_src_mac    = 48'h02_00_00_00_00_01;
    localparam logic [31:0] tb_src_ip     = {8'd192, 8'd168, 8'd1, 8'd10};
    localparam logic [15:0] tb_src_port   = 16'd5000;

    logic       logic_clk;
    logic       rst;
    logic [7:0] gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    logic [7:0] payload_data;
    logic       payload_valid;
    logic       payload_last;
    logic       payload_user;
    logic       payload_abort;

    // Frame table from the stimulus file
    logic [47:0] t_mac   [max_tests];
    logic [15:0] t_type  [max_tests];
    logic [7:0]  t_proto [max_tests];
    logic [31:0] t_ip    [max_tests];
    logic [15:0] t_port  [max_tests];
    logic [15:0] t_len   [max_tests];
    logic [15:0] t_err   [max_tests];
    logic [15:0] t_trunc [max_tests];
    logic        t_acc   [max_tests];
    int          n_tests;

    logic [7:0] frame_q[$];
    logic [7:0] payload_q[$];
    logic [7:0] exp_data[$];
    logic       exp_user[$];
    logic       exp_has_last;
    int         exp_abort;
    logic       rule_acc;

    logic [7:0] got_data[$];
    logic       got_user[$];
    logic       got_last[$];
    int         got_aborts;
    int         stray_flags;

    logic [31:0] lfsr;
    int          passed;
    int          failed;
    longint      watchdog_ns = 0;

    gmii_udp_rx dut (
        .logic_clk     (logic_clk),
        .rst           (rst),
        .gmii_rxd      (gmii_rxd),
        .gmii_rx_dv    (gmii_rx_dv),
        .gmii_rx_er    (gmii_rx_er),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .payload_last  (payload_last),
        .payload_user  (payload_user),
        .payload_abort (payload_abort)
    );

    initial begin
        logic_clk = 1'b0;
        forever #(clk_period / 2) logic_clk = ~logic_clk;
    end

    // x^32 + x^22 + x^2 + x + 1, shifting right
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        int    n;
        string line;
        n_tests = 0;
        fd = $fopen("testbench/udp_rx_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/udp_rx_stim.txt");
            return;
        end
        while (!$feof(fd) && n_tests < max_tests) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0) begin
                continue;
            end
            if (line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", t_mac[n_tests], t_type[n_tests],
                        t_proto[n_tests], t_ip[n_tests], t_port[n_tests], t_len[n_tests],
                        t_err[n_tests], t_trunc[n_tests], t_acc[n_tests]);
            if (n == 9) begin
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    // Big-endian field into the frame
    task automatic push_field(input logic [47:0] v, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            frame_q.push_back(v[8*i +: 8]);
        end
    endtask

    task automatic build_frame(input int idx);
        logic [15:0] udp_len;
        logic [7:0]  b;
        frame_q.delete();
        payload_q.delete();
        udp_len = t_len[idx] + 16'd8;
        push_field(t_mac[idx], 6);
        push_field(tb_src_mac, 6);
        push_field(t_type[idx], 2);
        push_field(tb_ver_ihl, 1);
        push_field(8'h00, 1);
        push_field(udp_len + 16'd20, 2);
        push_field(16'h0000, 2);
        push_field(16'h4000, 2);
        push_field(8'h40, 1);
        push_field(t_proto[idx], 1);
        push_field(16'h0000, 2);
        push_field(tb_src_ip, 4);
        push_field(t_ip[idx], 4);
        push_field(tb_src_port, 2);
        push_field(t_port[idx], 2);
        push_field(udp_len, 2);
        push_field(16'h0000, 2);
        for (int j = 0; j < int'(t_len[idx]); j++) begin
            random_byte(b);
            frame_q.push_back(b);
            payload_q.push_back(b);
        end
        push_field(32'hC0FF_EE00, fcs_len);
    endtask

    task automatic expected_results(input int idx);
        int   n_exp;
        int   err_idx;
        int   cut;
        logic err_sent;
        rule_acc = (t_mac[idx] == local_mac || t_mac[idx] == broadcast_mac)
                && t_type[idx] == tb_ipv4_type && t_proto[idx] == tb_udp_proto
                && t_ip[idx] == local_ip && t_port[idx] == udp_listen_port;
        cut      = (t_trunc[idx] == no_index) ? -1 : int'(t_trunc[idx]);
        err_idx  = (t_err[idx] == no_index) ? -1 : int'(t_err[idx]);
        err_sent = err_idx >= 0 && (cut < 0 || err_idx < cut);
        exp_abort = 0;
        n_exp = rule_acc ? int'(t_len[idx]) : 0;
        if (rule_acc && cut >= 0) begin
            if (cut <= hdr_bytes) begin
                n_exp = 0;
            end else if (cut - hdr_bytes < n_exp) begin
                n_exp = cut - hdr_bytes;
                exp_abort = 1;
            end
        end
        exp_has_last = n_exp > 0 && n_exp == int'(t_len[idx]);
        exp_data.delete();
        exp_user.delete();
        for (int j = 0; j < n_exp; j++) begin
            exp_data.push_back(payload_q[j]);
            exp_user.push_back(err_sent && err_idx <= hdr_bytes + j);
        end
    endtask

    task automatic drive_byte(input logic [7:0] b, input logic dv, input logic er);
        @(posedge logic_clk);
        gmii_rxd   <= b;
        gmii_rx_dv <= dv;
        gmii_rx_er <= er;
    endtask

    task automatic send_frame(input int idx);
        for (int i = 0; i < preamble_len; i++) begin
            drive_byte(8'h55, 1'b1, 1'b0);
        end
        drive_byte(8'hD5, 1'b1, 1'b0);
        for (int i = 0; i < frame_q.size(); i++) begin
            if (t_trunc[idx] != no_index && i >= int'(t_trunc[idx])) begin
                break;
            end
            drive_byte(frame_q[i], 1'b1, i == int'(t_err[idx]));
        end
        for (int i = 0; i < gap_cycles; i++) begin
            drive_byte(8'h00, 1'b0, 1'b0);
        end
    endtask

    task automatic check_frame(input int idx);
        int fails;
        fails = 0;
        if (rule_acc != t_acc[idx]) begin
            $display("test %0d: accept column in the stimulus file disagrees with the header",
                     idx);
            fails++;
        end
        if (got_data.size() != exp_data.size()) begin
            $display("[FAIL] test %0d payload_valid count got %h exp %h",
                     idx, got_data.size(), exp_data.size());
            fails++;
        end else begin
            for (int j = 0; j < exp_data.size(); j++) begin
                if (got_data[j] != exp_data[j]) begin
                    $display("[FAIL] test %0d payload_data[%0d] got %h exp %h",
                             idx, j, got_data[j], exp_data[j]);
                    fails++;
                end
                if (got_user[j] != exp_user[j]) begin
                    $display("[FAIL] test %0d payload_user[%0d] got %h exp %h",
                             idx, j, got_user[j], exp_user[j]);
                    fails++;
                end
                if (got_last[j] != (exp_has_last && j == exp_data.size() - 1)) begin
                    $display("[FAIL] test %0d payload_last[%0d] got %h exp %h",
                             idx, j, got_last[j], exp_has_last && j == exp_data.size() - 1);
                    fails++;
                end
            end
        end
        if (got_aborts != exp_abort) begin
            $display("[FAIL] test %0d payload_abort count got %h exp %h",
                     idx, got_aborts, exp_abort);
            fails++;
        end
        if (stray_flags != 0) begin
            $display("test %0d: payload_last came without a byte or with payload_abort", idx);
            fails++;
        end
        if (fails == 0) begin
            passed++;
            $display("test %0d ok: %0d payload bytes, abort %0d",
                     idx, got_data.size(), got_aborts);
        end else begin
            failed++;
            $display("test %0d failed with %0d mismatches", idx, fails);
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge logic_clk) begin
        if (!rst) begin
            if (payload_valid) begin
                got_data.push_back(payload_data);
                got_user.push_back(payload_user);
                got_last.push_back(payload_last);
            end else if (payload_last) begin
                stray_flags++;
            end
            if (payload_abort) begin
                got_aborts++;
                if (payload_last) begin
                    stray_flags++;
                end
            end
        end
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        longint total_cycles;
        rst         = 1'b1;
        gmii_rxd    = 8'h00;
        gmii_rx_dv  = 1'b0;
        gmii_rx_er  = 1'b0;
        lfsr        = 32'hb40e;
        passed      = 0;
        failed      = 0;
        got_aborts  = 0;
        stray_flags = 0;
        read_stimulus();
        total_cycles = reset_cycles + 2;
        for (int i = 0; i < n_tests; i++) begin
            total_cycles += preamble_len + 1 + hdr_bytes + t_len[i] + fcs_len + gap_cycles;
        end
        watchdog_ns = total_cycles * clk_period * 2;
        repeat (reset_cycles) @(posedge logic_clk);
        rst <= 1'b0;
        @(posedge logic_clk);
        for (int i = 0; i < n_tests; i++) begin
            build_frame(i);
            expected_results(i);
            got_data.delete();
            got_user.delete();
            got_last.delete();
            got_aborts  = 0;
            stray_flags = 0;
            send_frame(i);
            check_frame(i);
        end
        if (n_tests == 0) begin
            $display("No frames were read from the stimulus file");
        end
        $display("Summary: %0d tests, %0d passed, %0d failed", n_tests, passed, failed);
        if (failed == 0 && n_tests > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/udp_rx_stim.txt
# dest_mac ethertype proto dest_ip dest_port payload_len err_idx trunc_idx accept (hex)
# err_idx and trunc_idx count bytes after the SFD, ffff means none
02cafe123456 0800 11 c0a80180 04d2 0010 ffff ffff 1
ffffffffffff 0800 11 c0a80180 04d2 002e ffff ffff 1
02cafe123456 0800 11 c0a80180 04d3 0010 ffff ffff 0
02cafe123456 0800 11 c0a80181 04d2 0010 ffff ffff 0
02cafe123456 0800 06 c0a80180 04d2 0010 ffff ffff 0
02cafe123456 86dd 11 c0a80180 04d2 0010 ffff ffff 0
02cafe123457 0800 11 c0a80180 04d2 0010 ffff ffff 0
02cafe123456 0800 11 c0a80180 04d2 0020 0032 ffff 1
02cafe123456 0800 11 c0a80180 04d2 0018 0005 ffff 1
02cafe123456 0800 11 c0a80180 04d2 0040 ffff 0050 1
02cafe123456 0800 11 c0a80180 04d2 0008 ffff 002b 1
02cafe123456 0800 11 c0a80180 04d2 0001 ffff ffff 1
02cafe123456 0800 11 c0a80180 04d2 0010 ffff 0014 1
ffffffffffff 0800 11 c0a80180 04d2 0030 0040 0045 1
02cafe123456 0800 11 0a000001 04d2 0010 ffff ffff 0
02cafe123456 0800 11 c0a80180 04d2 0100 ffff ffff 1
123456789abc 0800 11 c0a80180 04d2 0010 0030 ffff 0
02cafe123456 0800 11 c0a80180 04d2 0005 0031 ffff 1
02cafe123456 0800 11 c0a80180 04d2 0040 ffff ffff 1
